//--- design/bridge_pkg.sv
package bridge_pkg;

	// ====================
	// Widths
	// ====================

	// Data word and bridge address
	localparam int DATA_W = 32;
	localparam int ADDR_W = 28;

	// Register index from address bits 4 to 2
	localparam int REG_W = 3;

	// Region code in the top bits of the bridge address
	localparam int REGION_W = 4;

	// LED pins driven by the system registers
	localparam int LED_W = 8;

	// Value returned by the ID register
	localparam logic [DATA_W-1:0] DEVICE_ID = 32'd3;

	// ====================
	// Encodings
	// ====================

	// Regions; any code not listed here is unmapped
	typedef enum logic [REGION_W-1:0] {
		REGION_NONE   = 4'h0,
		REGION_TIMER  = 4'h5,
		REGION_SYSREG = 4'h9
	} region_e;

	// Timer registers
	// CONTROL bit 0 is the enable and STATUS bit 0 the pending flag
	typedef enum logic [REG_W-1:0] {
		TMR_CONTROL = 3'd0,
		TMR_COMPARE = 3'd1,
		TMR_COUNTER = 3'd2,
		TMR_STATUS  = 3'd3
	} timer_reg_e;

	// System registers
	typedef enum logic [REG_W-1:0] {
		SYS_DEVICE_ID = 3'd0,
		SYS_LEDS      = 3'd1,
		SYS_SCRATCH   = 3'd2
	} sysreg_reg_e;

endpackage

//--- design/periph_if.sv
`timescale 1ns/1ps

interface periph_if
	import bridge_pkg::*;
();

	// Access from the decoder with a one-cycle request pulse
	logic              request;
	logic              rw;
	logic [REG_W-1:0]  index;
	logic [DATA_W-1:0] wdata;

	// Answer from the target one cycle after the request
	logic [DATA_W-1:0] rdata;
	logic              ready;

	modport decoder (
		output request, rw, index, wdata
	);

	modport target (
		input  request, rw, index, wdata,
		output rdata, ready
	);

	// Response side only looks at the answer
	modport collector (
		input rdata, ready
	);

endinterface

//--- design/bridge_decode.sv
`timescale 1ns/1ps

module bridge_decode
	import bridge_pkg::*;
(
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  logic              i_request,
	input  logic              i_rw,
	input  logic [ADDR_W-1:0] i_address,
	input  logic [DATA_W-1:0] i_wdata,
	periph_if.decoder         o_timer,
	periph_if.decoder         o_sysreg,
	output logic              o_unmapped,
	output region_e           o_region
);

	region_e region;
	logic    timer_select;
	logic    sysreg_select;

	// Region code in address bits 27 to 24
	assign region        = region_e'(i_address[ADDR_W-1 -: REGION_W]);
	assign timer_select  = (region == REGION_TIMER);
	assign sysreg_select = (region == REGION_SYSREG);

	// Only the selected target sees the strobe
	assign o_timer.request  = i_request && timer_select;
	assign o_sysreg.request = i_request && sysreg_select;
	assign o_unmapped       = i_request && !timer_select && !sysreg_select;

	// Shared access fields
	assign o_timer.rw     = i_rw;
	assign o_timer.index  = i_address[REG_W+1:2];
	assign o_timer.wdata  = i_wdata;
	assign o_sysreg.rw    = i_rw;
	assign o_sysreg.index = i_address[REG_W+1:2];
	assign o_sysreg.wdata = i_wdata;

	// Remember which region answers next cycle
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			o_region <= REGION_NONE;
		end else if (i_request) begin
			o_region <= region;
		end
	end

endmodule

//--- design/bridge_timer.sv
`timescale 1ns/1ps

module bridge_timer
	import bridge_pkg::*;
(
	input  logic     i_clock,
	input  logic     i_rst_n,
	periph_if.target bus,
	output logic     o_interrupt
);

	logic              enable;
	logic [DATA_W-1:0] compare;
	logic [DATA_W-1:0] counter;
	logic              pending;
	logic              write;
	logic              clear;
	logic              hit;
	logic [DATA_W-1:0] read_value;

	assign write = bus.request && bus.rw;

	// Writing a 1 to STATUS bit 0 acknowledges the interrupt
	assign clear = write && (timer_reg_e'(bus.index) == TMR_STATUS) && bus.wdata[0];
	assign hit   = enable && (counter == compare);

	// ====================
	// Registers
	// ====================

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			enable  <= 1'b0;
			compare <= '0;
		end else if (write) begin
			case (timer_reg_e'(bus.index))
				TMR_CONTROL: enable  <= bus.wdata[0];
				TMR_COMPARE: compare <= bus.wdata;
				default: ;
			endcase
		end
	end

	// Counts clock cycles and wraps after matching COMPARE
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			counter <= '0;
		end else if (hit) begin
			counter <= '0;
		end else if (enable) begin
			counter <= counter + DATA_W'(1);
		end
	end

	// A new match wins over a clear in the same cycle
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			pending <= 1'b0;
		end else if (hit) begin
			pending <= 1'b1;
		end else if (clear) begin
			pending <= 1'b0;
		end
	end

	assign o_interrupt = pending;

	// ====================
	// Read and answer
	// ====================

	always_comb begin
		case (timer_reg_e'(bus.index))
			TMR_CONTROL: read_value = {{(DATA_W-1){1'b0}}, enable};
			TMR_COMPARE: read_value = compare;
			TMR_COUNTER: read_value = counter;
			TMR_STATUS:  read_value = {{(DATA_W-1){1'b0}}, pending};
			default:     read_value = '0;
		endcase
	end

	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bus.ready <= 1'b0;
		end else begin
			bus.ready <= bus.request;
		end
	end

	// Writes answer with zero data
	always_ff @(posedge i_clock) begin
		if (bus.request) begin
			bus.rdata <= bus.rw ? '0 : read_value;
		end
	end

endmodule

//--- design/bridge_sysreg.sv
`timescale 1ns/1ps

module bridge_sysreg
	import bridge_pkg::*;
(
	input  logic             i_clock,
	input  logic             i_rst_n,
	periph_if.target         bus,
	output logic [LED_W-1:0] o_leds
);

	logic [LED_W-1:0]  leds;
	logic [DATA_W-1:0] scratch;
	logic [DATA_W-1:0] read_value;

	// DEVICE_ID is read-only, so only two registers take writes
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			leds    <= '0;
			scratch <= '0;
		end else if (bus.request && bus.rw) begin
			case (sysreg_reg_e'(bus.index))
				SYS_LEDS:    leds    <= bus.wdata[LED_W-1:0];
				SYS_SCRATCH: scratch <= bus.wdata;
				default: ;
			endcase
		end
	end

	assign o_leds = leds;

	always_comb begin
		case (sysreg_reg_e'(bus.index))
			SYS_DEVICE_ID: read_value = DEVICE_ID;
			SYS_LEDS:      read_value = {{(DATA_W-LED_W){1'b0}}, leds};
			SYS_SCRATCH:   read_value = scratch;
			// Unknown index
			default:       read_value = '0;
		endcase
	end

	// One cycle answer
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			bus.ready <= 1'b0;
		end else begin
			bus.ready <= bus.request;
		end
	end

	always_ff @(posedge i_clock) begin
		if (bus.request) begin
			bus.rdata <= bus.rw ? '0 : read_value;
		end
	end

endmodule

//--- design/bridge_response.sv
`timescale 1ns/1ps

module bridge_response
	import bridge_pkg::*;
(
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  region_e           i_region,
	input  logic              i_unmapped,
	periph_if.collector       i_timer,
	periph_if.collector       i_sysreg,
	output logic [DATA_W-1:0] o_rdata,
	output logic              o_ready
);

	logic unmapped_ready;

	// Stand-in answer for regions with no target
	always_ff @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			unmapped_ready <= 1'b0;
		end else begin
			unmapped_ready <= i_unmapped;
		end
	end

	// ====================
	// Result mux
	// ====================

	// Region was captured with the request, so it is stable here
	always_comb begin
		case (i_region)
			REGION_TIMER: begin
				o_rdata = i_timer.rdata;
				o_ready = i_timer.ready;
			end
			REGION_SYSREG: begin
				o_rdata = i_sysreg.rdata;
				o_ready = i_sysreg.ready;
			end
			default: begin
				o_rdata = '0;
				o_ready = unmapped_ready;
			end
		endcase
	end

endmodule

//--- design/periph_bridge.sv
`timescale 1ns/1ps

module periph_bridge
	import bridge_pkg::*;
(
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  logic              i_request,
	input  logic              i_rw,
	input  logic [ADDR_W-1:0] i_address,
	input  logic [DATA_W-1:0] i_wdata,
	output logic [DATA_W-1:0] o_rdata,
	output logic              o_ready,
	output logic              o_timer_interrupt,
	output logic [LED_W-1:0]  o_leds
);

	periph_if timer_bus ();
	periph_if sysreg_bus ();

	logic    unmapped;
	region_e region;

	// ====================
	// Decode
	// ====================

	bridge_decode decode (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_request  (i_request),
		.i_rw       (i_rw),
		.i_address  (i_address),
		.i_wdata    (i_wdata),
		.o_timer    (timer_bus.decoder),
		.o_sysreg   (sysreg_bus.decoder),
		.o_unmapped (unmapped),
		.o_region   (region)
	);

	// Region 5
	bridge_timer timer (
		.i_clock     (i_clock),
		.i_rst_n     (i_rst_n),
		.bus         (timer_bus.target),
		.o_interrupt (o_timer_interrupt)
	);

	// Region 9
	bridge_sysreg sysreg (
		.i_clock (i_clock),
		.i_rst_n (i_rst_n),
		.bus     (sysreg_bus.target),
		.o_leds  (o_leds)
	);

	// ====================
	// Result
	// ====================

	bridge_response response (
		.i_clock    (i_clock),
		.i_rst_n    (i_rst_n),
		.i_region   (region),
		.i_unmapped (unmapped),
		.i_timer    (timer_bus.collector),
		.i_sysreg   (sysreg_bus.collector),
		.o_rdata    (o_rdata),
		.o_ready    (o_ready)
	);

endmodule

//--- testbench/bridge_checker.sv
`timescale 1ns/1ps

module bridge_checker
	import bridge_pkg::*;
(
	input  logic              i_clock,
	input  logic              i_rst_n,
	input  logic              i_request,
	input  logic              i_rw,
	input  logic [ADDR_W-1:0] i_address,
	input  logic [DATA_W-1:0] i_wdata,
	input  logic [DATA_W-1:0] i_rdata,
	input  logic              i_ready,
	input  logic              i_timer_interrupt,
	input  logic [LED_W-1:0]  i_leds,
	output int                o_value_errors,
	output int                o_handshake_errors
);

	logic [DATA_W-1:0] scratch_model;
	logic [DATA_W-1:0] compare_model;
	logic [DATA_W-1:0] expected;
	logic [LED_W-1:0]  leds_model;
	logic              enable_model;
	logic              pend_model;
	logic              ready_due;
	logic              write_due;
	logic              counter_due;
	logic              clear_due;
	logic [3:0]        region;
	logic [2:0]        index;

	assign region = i_address[27:24];
	assign index  = i_address[4:2];

	// Expected read data for a region and register index
	function automatic logic [DATA_W-1:0] ref_read(input logic [3:0] reg_region,
			input logic [2:0] reg_index);
		logic [DATA_W-1:0] value;
		value = '0;
		if (reg_region == 4'h5) begin
			case (reg_index)
				3'd0: value = {31'd0, enable_model};
				3'd1: value = compare_model;
				3'd3: value = {31'd0, pend_model};
				default: value = '0;
			endcase
		end else if (reg_region == 4'h9) begin
			case (reg_index)
				3'd0: value = 32'd3;
				3'd1: value = {24'd0, leds_model};
				3'd2: value = scratch_model;
				default: value = '0;
			endcase
		end
		return value;
	endfunction

	task automatic report(input string name, input logic [DATA_W-1:0] exp_value,
			input logic [DATA_W-1:0] act_value);
		$display("CHECK FAILED at %0t: %s expected %h actual %h", $time, name, exp_value,
			act_value);
		o_value_errors++;
	endtask

	// ====================
	// Compare
	// ====================

	always @(posedge i_clock or negedge i_rst_n) begin
		if (!i_rst_n) begin
			scratch_model      <= '0;
			compare_model      <= '0;
			leds_model         <= '0;
			enable_model       <= 1'b0;
			pend_model         <= 1'b0;
			expected           <= '0;
			ready_due          <= 1'b0;
			write_due          <= 1'b0;
			counter_due        <= 1'b0;
			clear_due          <= 1'b0;
			o_value_errors     = 0;
			o_handshake_errors = 0;
		end else begin
			// Ready exactly one cycle after each request, and never otherwise
			if (i_ready !== ready_due) begin
				$display("CHECK FAILED at %0t: o_ready expected %b actual %b", $time,
					ready_due, i_ready);
				o_handshake_errors++;
			end
			if (ready_due && i_ready === 1'b1) begin
				if (counter_due) begin
					// Only a bound on the free-running count
					if (i_rdata > compare_model)
						report("o_rdata (COUNTER bound)", compare_model, i_rdata);
				end else if (i_rdata !== expected) begin
					report("o_rdata", expected, i_rdata);
				end
			end
			if (write_due && i_leds !== leds_model)
				report("o_leds", {24'd0, leds_model}, {24'd0, i_leds});
			if (clear_due && i_timer_interrupt !== 1'b0)
				report("o_timer_interrupt", 32'd0, {31'd0, i_timer_interrupt});

			if (i_timer_interrupt === 1'b1)
				pend_model <= 1'b1;
			ready_due   <= i_request;
			write_due   <= i_request && i_rw;
			counter_due <= i_request && !i_rw && region == 4'h5 && index == 3'd2;
			clear_due   <= i_request && i_rw && region == 4'h5 && index == 3'd3 && i_wdata[0];

			if (i_request) begin
				expected <= i_rw ? '0 : ref_read(region, index);
				if (i_rw && region == 4'h5) begin
					case (index)
						3'd0: enable_model  <= i_wdata[0];
						3'd1: compare_model <= i_wdata;
						3'd3: if (i_wdata[0]) pend_model <= 1'b0;
						default: ;
					endcase
				end else if (i_rw && region == 4'h9) begin
					case (index)
						3'd1: leds_model    <= i_wdata[7:0];
						3'd2: scratch_model <= i_wdata;
						default: ;
					endcase
				end
			end
		end
	end

endmodule

//--- testbench/tb_periph_bridge.sv
`timescale 1ns/1ps

module tb_periph_bridge
	import bridge_pkg::*;
();

	localparam int READY_TIMEOUT = 8;
	localparam int IRQ_TIMEOUT   = 60;

	logic              i_clock;
	logic              i_rst_n;
	logic              i_request;
	logic              i_rw;
	logic [ADDR_W-1:0] i_address;
	logic [DATA_W-1:0] i_wdata;
	logic [DATA_W-1:0] o_rdata;
	logic              o_ready;
	logic              o_timer_interrupt;
	logic [LED_W-1:0]  o_leds;
	int                value_errors;
	int                handshake_errors;
	int                timeout_errors;
	logic [31:0]       lfsr;
	logic [1:0]        pick;
	logic              do_write;
	logic [DATA_W-1:0] data;

	periph_bridge periph_bridge_inst (.*);

	bridge_checker checks (
		.i_clock            (i_clock),
		.i_rst_n            (i_rst_n),
		.i_request          (i_request),
		.i_rw               (i_rw),
		.i_address          (i_address),
		.i_wdata            (i_wdata),
		.i_rdata            (o_rdata),
		.i_ready            (o_ready),
		.i_timer_interrupt  (o_timer_interrupt),
		.i_leds             (o_leds),
		.o_value_errors     (value_errors),
		.o_handshake_errors (handshake_errors)
	);

	initial begin
		i_clock = 1'b0;
		forever #20 i_clock = ~i_clock;
	end

	// Fibonacci LFSR with taps 32 22 2 1 and one step per bit taken
	function automatic logic [31:0] take_bits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsr  = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			value = {value[30:0], lfsr[0]};
		end
		return value;
	endfunction

	// One request cycle and a wait for the answer
	task automatic access(input logic rw, input logic [3:0] region, input logic [2:0] index,
			input logic [DATA_W-1:0] wdata);
		int cycles;
		i_request <= 1'b1;
		i_rw      <= rw;
		i_address <= {region, 19'd0, index, 2'b00};
		i_wdata   <= wdata;
		@(posedge i_clock);
		i_request <= 1'b0;
		cycles = 0;
		do begin
			@(posedge i_clock);
			cycles++;
		end while (o_ready !== 1'b1 && cycles < READY_TIMEOUT);
		if (o_ready !== 1'b1) begin
			$display("Timeout at %0t: no ready for region %h index %0d", $time, region, index);
			timeout_errors++;
		end
	endtask

	task automatic wait_interrupt();
		int cycles;
		cycles = 0;
		while (o_timer_interrupt !== 1'b1 && cycles < IRQ_TIMEOUT) begin
			@(posedge i_clock);
			cycles++;
		end
		if (o_timer_interrupt !== 1'b1) begin
			$display("Timeout at %0t: timer interrupt never rose", $time);
			timeout_errors++;
		end
	endtask

	// ====================
	// Stimulus
	// ====================

	initial begin
		i_rst_n        = 1'b0;
		i_request      = 1'b0;
		i_rw           = 1'b0;
		i_address      = '0;
		i_wdata        = '0;
		timeout_errors = 0;
		lfsr           = 32'h5767_92e3;
		repeat (4) @(posedge i_clock);
		i_rst_n <= 1'b1;
		@(posedge i_clock);

		// ID, LED and scratch registers
		access(1'b0, 4'h9, 3'd0, '0);
		access(1'b1, 4'h9, 3'd1, take_bits(32));
		access(1'b1, 4'h9, 3'd2, take_bits(32));
		access(1'b0, 4'h9, 3'd1, '0);
		access(1'b0, 4'h9, 3'd2, '0);
		access(1'b1, 4'h9, 3'd0, take_bits(32));
		access(1'b0, 4'h9, 3'd0, '0);

		// Unmapped regions must not disturb the system registers
		access(1'b0, 4'h2, 3'd0, '0);
		access(1'b1, 4'hf, 3'd1, take_bits(32));
		access(1'b0, 4'h9, 3'd1, '0);
		access(1'b0, 4'h9, 3'd2, '0);

		// Timer interrupt and acknowledge
		access(1'b1, 4'h5, 3'd1, 32'd20);
		access(1'b1, 4'h5, 3'd0, 32'd1);
		wait_interrupt();
		access(1'b0, 4'h5, 3'd3, '0);
		access(1'b1, 4'h5, 3'd3, 32'd1);
		access(1'b0, 4'h5, 3'd2, '0);

		// Random mix without COUNTER and STATUS
		for (int n = 0; n < 40; n++) begin
			pick     = 2'(take_bits(2));
			do_write = 1'(take_bits(1));
			data     = take_bits(32);
			case (pick)
				2'd0: access(do_write, 4'h9, 3'd2, data);
				2'd1: access(do_write, 4'h9, 3'd1, data);
				2'd2: access(do_write, 4'h5, 3'd1, data);
				default: access(do_write, 4'h5, 3'd0, data);
			endcase
		end

		repeat (2) @(posedge i_clock);
		$display("Errors: value %0d, handshake %0d, timeout %0d", value_errors,
			handshake_errors, timeout_errors);
		if (value_errors + handshake_errors + timeout_errors == 0) begin
			$display("Simulation passed");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

endmodule

//--- flist.f
design/bridge_pkg.sv
design/periph_if.sv
design/bridge_decode.sv
design/bridge_timer.sv
design/bridge_sysreg.sv
design/bridge_response.sv
design/periph_bridge.sv
testbench/bridge_checker.sv
testbench/tb_periph_bridge.sv

//--- Bender.yml
package:
  name: periph_bridge

sources:
  - files:
      - design/bridge_pkg.sv
      - design/periph_if.sv
      - design/bridge_decode.sv
      - design/bridge_timer.sv
      - design/bridge_sysreg.sv
      - design/bridge_response.sv
      - design/periph_bridge.sv
  - target: test
    files:
      - testbench/bridge_checker.sv
      - testbench/tb_periph_bridge.sv
